//--- all.f
+incdir+hdl
hdl/arrayOpPkg.sv
hdl/arrayCtlPkg.sv
hdl/arrayIf.sv
hdl/commandDecoder.sv
hdl/arrayStore.sv
hdl/responseStage.sv
hdl/arrayMemoryTop.sv
test/arrayMemory_asserts.sv
test/arrayMemoryTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module arrayMemoryTb -o arrayMemorySim

result=$(./obj_dir/arrayMemorySim || true)
echo "$result"
if grep -qx "ALL CHECKS PASSED" <<< "$result"; then
  exit 0
fi
exit 1

//--- test/arrayMemoryTb.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module arrayMemoryTb;

  localparam int Period        = 8;
  localparam int Slots         = `SLOTS;
  localparam int Seed          = 98593;
  localparam int CmdLimit      = 2 + `ARRAYS + Slots + 4;     // Longest command plus slack
  localparam int RandomMix     = 300;
  localparam int TotalCommands = 700;
  localparam int WatchdogTime  = Period * (TotalCommands * (2 + `ARRAYS + Slots) + 200);

  logic                   clock;
  logic                   arstN;
  logic                   start;
  logic [7:0]             action;
  arrayCtlPkg::arrayId_t  array;
  logic [`INDEX_BITS-1:0] index;
  logic [`DATA_BITS-1:0]  in;
  logic [`DATA_BITS-1:0]  out;
  logic                   done;
  logic                   busy;

  logic [`DATA_BITS-1:0]  refMem [`ARRAYS][Slots];   // Model of the element storage
  int                     refSize [`ARRAYS];
  int                     markArray;
  int                     markIndex;
  logic [`DATA_BITS-1:0]  refOut;

  logic [`DATA_BITS-1:0]  expectOut;
  string                  lastCmd;
  int unsigned            lcgState;
  int                     errorCount;
  int                     checkCount;
  int                     testNumber;
  int                     errorsBefore;

  arrayOpPkg::opcode_t opList [14] = '{
    arrayOpPkg::Clear, arrayOpPkg::Write, arrayOpPkg::Read, arrayOpPkg::Size,
    arrayOpPkg::Inc, arrayOpPkg::Dec, arrayOpPkg::Index, arrayOpPkg::Less,
    arrayOpPkg::Greater, arrayOpPkg::Insert, arrayOpPkg::MoveMark,
    arrayOpPkg::MoveCopy, arrayOpPkg::Push, arrayOpPkg::Pop
  };

  arrayMemoryTop i_arrayMemoryTop (
    .clock  (clock),
    .arstN  (arstN),
    .start  (start),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .done   (done),
    .busy   (busy)
  );

  always #(Period / 2) clock = ~clock;

  function automatic int unsigned lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 8;
  endfunction

  // Applies one command to the model and returns what out should show
  function automatic logic [`DATA_BITS-1:0] refExecute(input arrayOpPkg::opcode_t op,
                                                       input int a, input int i,
                                                       input logic [`DATA_BITS-1:0] d);
    int hits;
    int src;
    int dst;
    case (op)
      arrayOpPkg::Clear: begin
        for (int k = 0; k < `ARRAYS; k++) refSize[k] = 0;
      end
      arrayOpPkg::Write: begin
        refMem[a][i] = d;
        if (i >= refSize[a]) refSize[a] = i + 1;        // Past the end grows
        refOut = d;
      end
      arrayOpPkg::Read: refOut = refMem[a][i];
      arrayOpPkg::Size: refOut = `DATA_BITS'(refSize[a]);
      arrayOpPkg::Inc: if (refSize[a] < Slots) refSize[a]++;
      arrayOpPkg::Dec: if (refSize[a] > 0) refSize[a]--;
      arrayOpPkg::Index, arrayOpPkg::Less, arrayOpPkg::Greater: begin
        hits = 0;
        for (int k = 0; k < refSize[a]; k++) begin
          if (op == arrayOpPkg::Index && refMem[a][k] == d) hits = k + 1;
          if (op == arrayOpPkg::Less && refMem[a][k] < d) hits++;
          if (op == arrayOpPkg::Greater && refMem[a][k] > d) hits++;
        end
        refOut = `DATA_BITS'(hits);
      end
      arrayOpPkg::Insert: begin
        for (int k = Slots - 1; k > i; k--) begin
          if (k <= refSize[a]) refMem[a][k] = refMem[a][k - 1];
        end
        refMem[a][i] = d;
        if (refSize[a] < Slots) refSize[a]++;           // Full array loses its top
      end
      arrayOpPkg::MoveMark: begin
        markArray = a;
        markIndex = i;
      end
      arrayOpPkg::MoveCopy: begin
        for (int k = 0; k < Slots && k < int'(d); k++) begin
          src = markIndex + k;
          dst = i + k;
          if (src < Slots && dst < Slots) begin
            refMem[a][dst] = refMem[markArray][src];
            if (dst >= refSize[a]) refSize[a] = dst + 1;
          end
        end
      end
      arrayOpPkg::Push: begin
        if (refSize[a] < Slots) begin
          refMem[a][refSize[a]] = d;
          refSize[a]++;
        end
      end
      arrayOpPkg::Pop: begin
        if (refSize[a] > 0) begin
          refSize[a]--;
          refOut = refMem[a][refSize[a]];
        end
      end
      default: ;
    endcase
    return refOut;
  endfunction

  task automatic checkValue(input logic [`DATA_BITS-1:0] got, input logic [`DATA_BITS-1:0] want,
                            input string what);
    checkCount++;
    if (got !== want) begin
      $display("FAILED %0d ns: %s gave %0h, expected %0h", $time, what, got, want);
      errorCount++;
    end
  endtask

  task automatic issueCommand(input arrayOpPkg::opcode_t op, input int a, input int i,
                              input int d);
    arrayCtlPkg::arrayId_t  aBits;
    logic [`INDEX_BITS-1:0] iBits;
    logic [`DATA_BITS-1:0]  dBits;
    int                     waited;
    aBits = arrayCtlPkg::arrayId_t'(a);
    iBits = `INDEX_BITS'(i);
    dBits = `DATA_BITS'(d);
    @(negedge clock);
    start  = 1'b1;
    action = op;
    array  = aBits;
    index  = iBits;
    in     = dBits;
    lastCmd   = $sformatf("%s array %0d index %0d data %0h", op.name(), aBits, iBits, dBits);
    expectOut = refExecute(op, int'(aBits), int'(iBits), dBits);
    @(negedge clock);
    start  = 1'b0;
    waited = 0;
    while (!done && waited < CmdLimit) begin
      @(negedge clock);
      waited++;
      if (!done) begin
        checkValue(`DATA_BITS'(busy), `DATA_BITS'(1), {lastCmd, " busy while running"});
      end
    end
    if (!done) begin
      $display("Timeout: %s got no done within %0d cycles", lastCmd, CmdLimit);
      errorCount++;
    end
  endtask

  task automatic endTest(input string name);
    @(negedge clock);                                   // Let the last compare land
    $display("Test %0d %s finished with %0d errors", testNumber, name,
             errorCount - errorsBefore);
    testNumber++;
    errorsBefore = errorCount;
  endtask

  // Compare out on every done pulse
  always @(negedge clock) begin
    if (arstN && done) begin
      checkValue(out, expectOut, lastCmd);
      checkValue(`DATA_BITS'(busy), `DATA_BITS'(0), {lastCmd, " busy at done"});
    end
  end

  initial begin
    #(WatchdogTime);
    $display("Watchdog stopped the run before the tests ended");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int key;
    clock = 1'b0;
    arstN = 1'b0;
    start = 1'b0;
    action = '0;
    array = '0;
    index = '0;
    in = '0;
    lcgState = Seed;
    errorCount = 0;
    checkCount = 0;
    testNumber = 0;
    errorsBefore = 0;
    refOut = '0;
    markArray = 0;
    markIndex = 0;
    for (int a = 0; a < `ARRAYS; a++) refSize[a] = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    arstN = 1'b1;
    checkValue(out, '0, "out after reset");

    // Every slot gets known data first
    for (int a = 0; a < `ARRAYS; a++) begin
      for (int k = 0; k < Slots; k++) issueCommand(arrayOpPkg::Write, a, k, lcgNext());
    end
    issueCommand(arrayOpPkg::Clear, 0, 0, 0);
    endTest("fill");

    issueCommand(arrayOpPkg::Write, 3, 5, 8'hA5);
    issueCommand(arrayOpPkg::Size, 3, 0, 0);
    issueCommand(arrayOpPkg::Read, 3, 5, 0);
    issueCommand(arrayOpPkg::Read, 3, 2, 0);
    issueCommand(arrayOpPkg::Write, 3, 1, 8'h11);
    issueCommand(arrayOpPkg::Size, 3, 0, 0);
    endTest("write read size");

    issueCommand(arrayOpPkg::Pop, 4, 0, 0);               // Empty array
    for (int k = 0; k <= Slots; k++) issueCommand(arrayOpPkg::Push, 4, 0, 8'h40 + k);
    issueCommand(arrayOpPkg::Size, 4, 0, 0);
    for (int k = 0; k < Slots; k++) issueCommand(arrayOpPkg::Read, 4, k, 0);
    repeat (3) issueCommand(arrayOpPkg::Pop, 4, 0, 0);
    issueCommand(arrayOpPkg::Size, 4, 0, 0);
    endTest("push pop");

    repeat (Slots + 2) issueCommand(arrayOpPkg::Inc, 5, 0, 0);
    issueCommand(arrayOpPkg::Size, 5, 0, 0);
    repeat (Slots + 2) issueCommand(arrayOpPkg::Dec, 5, 0, 0);
    issueCommand(arrayOpPkg::Size, 5, 0, 0);
    repeat (3) issueCommand(arrayOpPkg::Inc, 5, 0, 0);
    issueCommand(arrayOpPkg::Clear, 0, 0, 0);
    issueCommand(arrayOpPkg::Size, 5, 0, 0);
    issueCommand(arrayOpPkg::Size, 4, 0, 0);
    issueCommand(arrayOpPkg::Pop, 4, 0, 0);
    endTest("inc dec clear");

    for (int a = 6; a < 10; a++) begin
      for (int k = 0; k < Slots; k++) issueCommand(arrayOpPkg::Write, a, k, lcgNext() % 8);
      repeat (lcgNext() % 4) issueCommand(arrayOpPkg::Dec, a, 0, 0);
      issueCommand(arrayOpPkg::Size, a, 0, 0);
      repeat (4) begin
        key = lcgNext() % 8;                              // Small keys so matches occur
        issueCommand(arrayOpPkg::Index, a, 0, key);
        issueCommand(arrayOpPkg::Less, a, 0, key);
        issueCommand(arrayOpPkg::Greater, a, 0, key);
      end
    end
    endTest("scans");

    for (int k = 0; k < 3; k++) issueCommand(arrayOpPkg::Push, 10, 0, 8'h50 + k);
    issueCommand(arrayOpPkg::Insert, 10, 1, 8'hE1);
    issueCommand(arrayOpPkg::Insert, 10, 0, 8'hE0);
    issueCommand(arrayOpPkg::Insert, 10, 7, 8'hE7);
    issueCommand(arrayOpPkg::Push, 10, 0, 8'h61);
    issueCommand(arrayOpPkg::Push, 10, 0, 8'h62);
    issueCommand(arrayOpPkg::Insert, 10, 2, 8'hEE);      // Full, top drops off
    for (int k = 0; k < Slots; k++) issueCommand(arrayOpPkg::Read, 10, k, 0);
    issueCommand(arrayOpPkg::Size, 10, 0, 0);
    endTest("insert");

    issueCommand(arrayOpPkg::MoveMark, 11, 2, 0);
    issueCommand(arrayOpPkg::MoveCopy, 12, 3, 4);
    issueCommand(arrayOpPkg::Size, 12, 0, 0);
    issueCommand(arrayOpPkg::MoveCopy, 12, 6, 9);        // Clipped by the target end
    issueCommand(arrayOpPkg::MoveMark, 12, 0, 0);
    issueCommand(arrayOpPkg::MoveCopy, 12, 1, 8);        // Overlapping run
    for (int k = 0; k < Slots; k++) issueCommand(arrayOpPkg::Read, 12, k, 0);
    issueCommand(arrayOpPkg::Size, 12, 0, 0);
    endTest("long move");

    for (int n = 0; n < RandomMix; n++) begin
      issueCommand(opList[lcgNext() % 14], lcgNext() % `ARRAYS, lcgNext() % Slots,
                   lcgNext() % 16);
    end
    for (int a = 0; a < `ARRAYS; a++) issueCommand(arrayOpPkg::Size, a, 0, 0);
    endTest("random mix");

    $display("Summary: %0d tests, %0d checks, %0d errors", testNumber, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- test/arrayMemory_asserts.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module arrayMemoryAsserts (
  input logic               clock,
  input logic               arstN,
  input logic               valid,
  input logic               finish,
  input logic               done,
  input logic               busy,
  input logic               sizeWe,
  input arrayCtlPkg::size_t sizeData
);

  // Only one command may be outstanding
  noValidWhileBusy: assert property (@(posedge clock) disable iff (!arstN) valid |-> !busy)
    else $error("Command accepted while engine busy");

  doneAfterFinish: assert property (@(posedge clock) disable iff (!arstN) finish |=> done)
    else $error("Finish not followed by done");

  // Busy falls on the same edge that raises done
  busyClearAtDone: assert property (@(posedge clock) disable iff (!arstN) done |-> !busy)
    else $error("Busy still high while done is shown");

  sizeInRange: assert property (@(posedge clock) disable iff (!arstN)
    sizeWe |-> (sizeData <= `SLOTS))
    else $error("Array size written beyond slot count");

  quietInReset: assert property (@(posedge clock) !arstN |-> (!done && !busy))
    else $error("Done or busy high during reset");

endmodule

// Size writes exist only inside the store
bind arrayStore arrayMemoryAsserts storeChecks (
  .clock    (clock),
  .arstN    (arstN),
  .valid    (1'b0),
  .finish   (1'b0),
  .done     (1'b0),
  .busy     (1'b0),
  .sizeWe   (sizeWe),
  .sizeData (sizeData)
);

bind responseStage arrayMemoryAsserts responseChecks (
  .clock    (clock),
  .arstN    (arstN),
  .valid    (issued),
  .finish   (rsp.finish),
  .done     (done),
  .busy     (busy),
  .sizeWe   (1'b0),
  .sizeData ('0)
);

//--- hdl/arrayMemoryTop.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module arrayMemoryTop (
  input  logic                   clock,
  input  logic                   arstN,
  input  logic                   start,
  input  logic [7:0]             action,
  input  arrayCtlPkg::arrayId_t  array,
  input  logic [`INDEX_BITS-1:0] index,
  input  logic [`DATA_BITS-1:0]  in,
  output logic [`DATA_BITS-1:0]  out,
  output logic                   done,
  output logic                   busy
);

  arrayCmdIf cmdBus ();                     // Decoder to store
  arrayRspIf rspBus ();                     // Store to response

  commandDecoder decoder (
    .clock  (clock),
    .arstN  (arstN),
    .start  (start),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .busy   (busy),
    .cmd    (cmdBus.source)
  );

  arrayStore store (
    .clock (clock),
    .arstN (arstN),
    .cmd   (cmdBus.sink),
    .rsp   (rspBus.source)
  );

  responseStage response (
    .clock  (clock),
    .arstN  (arstN),
    .issued (cmdBus.valid),
    .rsp    (rspBus.sink),
    .out    (out),
    .done   (done),
    .busy   (busy)
  );

endmodule

//--- hdl/responseStage.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module responseStage (
  input  logic                  clock,
  input  logic                  arstN,
  input  logic                  issued,
  arrayRspIf.sink               rsp,
  output logic [`DATA_BITS-1:0] out,
  output logic                  done,
  output logic                  busy
);

  logic                  countResult;
  logic [`DATA_BITS-1:0] shown;

  // Sizes and counts only occupy the low size bits
  always_comb begin
    case (rsp.opcode)
      arrayOpPkg::Size,
      arrayOpPkg::Index,
      arrayOpPkg::Less,
      arrayOpPkg::Greater: countResult = 1'b1;
      default:             countResult = 1'b0;
    endcase
  end

  assign shown = countResult ? `DATA_BITS'(rsp.value[`INDEX_BITS:0]) : rsp.value;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      out  <= '0;
      done <= 1'b0;
      busy <= 1'b0;
    end else begin
      done <= rsp.finish;                   // One cycle behind finish
      if (rsp.finish && rsp.hasValue) begin
        out <= shown;
      end
      if (issued) begin
        busy <= 1'b1;
      end else if (rsp.finish) begin
        busy <= 1'b0;                       // Falls as done rises
      end
    end
  end

endmodule

//--- hdl/arrayStore.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module arrayStore (
  input logic        clock,
  input logic        arstN,
  arrayCmdIf.sink    cmd,
  arrayRspIf.source  rsp
);

  localparam arrayCtlPkg::size_t FullSize = arrayCtlPkg::size_t'(`SLOTS);

  logic [`DATA_BITS-1:0] mem [`ARRAYS][`SLOTS];      // Fixed block per array
  arrayCtlPkg::size_t    sizes [`ARRAYS];            // Current size per array

  arrayCtlPkg::arrayId_t  markArray;                 // Long move source array
  logic [`INDEX_BITS-1:0] markIndex;                 // Long move source index

  arrayCtlPkg::state_t    state;
  arrayCtlPkg::step_t     step;
  logic                   lastStep;
  logic [`INDEX_BITS-1:0] slot;
  logic                   take;

  arrayOpPkg::opcode_t    curOp;                     // Latched for multi-cycle work
  arrayCtlPkg::arrayId_t  curArray;
  logic [`INDEX_BITS-1:0] curIndex;
  logic [`DATA_BITS-1:0]  curData;
  arrayCtlPkg::size_t     curSize;
  arrayCtlPkg::size_t     acc;                       // Running scan result
  arrayCtlPkg::size_t     accNext;

  arrayCtlPkg::size_t     cmdSize;
  logic                   cmdFull;
  logic                   cmdEmpty;
  logic [`INDEX_BITS-1:0] popSlot;

  logic [`DATA_BITS-1:0]  scanElem;
  logic                   inSize;
  logic                   hit;
  logic [`INDEX_BITS-1:0] insSlot;
  logic [`INDEX_BITS-1:0] shiftSrc;
  arrayCtlPkg::size_t     srcPos;
  arrayCtlPkg::size_t     dstPos;
  logic                   copyOk;

  logic                   memWe;                     // Single write port
  arrayCtlPkg::arrayId_t  memArray;
  logic [`INDEX_BITS-1:0] memSlot;
  logic [`DATA_BITS-1:0]  memData;
  logic                   sizeWe;
  arrayCtlPkg::arrayId_t  sizeArray;
  arrayCtlPkg::size_t     sizeData;

  assign take     = (state == arrayCtlPkg::Idle) && cmd.valid;
  assign slot     = step[`INDEX_BITS-1:0];
  assign lastStep = (state == arrayCtlPkg::Clearing) ?
                    (step == arrayCtlPkg::step_t'(`ARRAYS - 1)) :
                    (step == arrayCtlPkg::step_t'(`SLOTS - 1));

  assign cmdSize  = sizes[cmd.array];
  assign cmdFull  = cmdSize == FullSize;
  assign cmdEmpty = cmdSize == '0;
  assign popSlot  = cmdSize[`INDEX_BITS-1:0] - 1'b1;  // Wraps to top slot when full

  assign curSize  = sizes[curArray];
  assign scanElem = mem[curArray][slot];
  assign inSize   = {1'b0, slot} < curSize;
  assign insSlot  = ~slot;                           // Top slot down
  assign shiftSrc = insSlot - 1'b1;
  assign srcPos   = {1'b0, markIndex} + {1'b0, slot};
  assign dstPos   = {1'b0, curIndex} + {1'b0, slot};
  assign copyOk   = (`DATA_BITS'(slot) < curData) && !srcPos[`INDEX_BITS] &&
                    !dstPos[`INDEX_BITS];

  always_comb begin
    case (curOp)
      arrayOpPkg::Less:    hit = scanElem < curData;
      arrayOpPkg::Greater: hit = scanElem > curData;
      default:             hit = scanElem == curData;
    endcase
    if (curOp == arrayOpPkg::Index) begin
      accNext = (hit && inSize) ? {1'b0, slot} + 1'b1 : acc;
    end else begin
      accNext = acc + arrayCtlPkg::size_t'(hit && inSize);
    end
  end

  always_comb begin
    memWe     = 1'b0;
    memArray  = cmd.array;
    memSlot   = cmd.index;
    memData   = cmd.data;
    sizeWe    = 1'b0;
    sizeArray = cmd.array;
    sizeData  = cmdSize;
    case (state)
      arrayCtlPkg::Idle: begin
        if (cmd.valid) begin
          case (cmd.opcode)
            arrayOpPkg::Write: begin
              memWe = 1'b1;
              if ({1'b0, cmd.index} >= cmdSize) begin  // Past the end grows
                sizeWe   = 1'b1;
                sizeData = {1'b0, cmd.index} + 1'b1;
              end
            end
            arrayOpPkg::Inc: begin
              sizeWe   = !cmdFull;
              sizeData = cmdSize + 1'b1;
            end
            arrayOpPkg::Dec: begin
              sizeWe   = !cmdEmpty;
              sizeData = cmdSize - 1'b1;
            end
            arrayOpPkg::Push: begin
              memWe    = !cmdFull;
              memSlot  = cmdSize[`INDEX_BITS-1:0];
              sizeWe   = !cmdFull;
              sizeData = cmdSize + 1'b1;
            end
            arrayOpPkg::Pop: begin
              sizeWe   = !cmdEmpty;
              sizeData = cmdSize - 1'b1;
            end
            default: ;
          endcase
        end
      end
      arrayCtlPkg::Clearing: begin
        sizeWe    = 1'b1;
        sizeArray = arrayCtlPkg::arrayId_t'(step);
        sizeData  = '0;
      end
      arrayCtlPkg::Shifting: begin
        memArray = curArray;
        memSlot  = insSlot;
        if (insSlot == curIndex) begin
          memWe   = 1'b1;
          memData = curData;
        end else if (insSlot > curIndex && {1'b0, insSlot} <= curSize) begin
          memWe   = 1'b1;
          memData = mem[curArray][shiftSrc];
        end
        sizeArray = curArray;
        sizeWe    = lastStep && (curSize != FullSize);  // Full array drops top element
        sizeData  = curSize + 1'b1;
      end
      arrayCtlPkg::Copying: begin
        memArray  = curArray;
        memSlot   = dstPos[`INDEX_BITS-1:0];
        memData   = mem[markArray][srcPos[`INDEX_BITS-1:0]];
        memWe     = copyOk;
        sizeArray = curArray;
        sizeWe    = copyOk && (dstPos >= curSize);
        sizeData  = dstPos + 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (memWe) begin
      mem[memArray][memSlot] <= memData;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int a = 0; a < `ARRAYS; a++) begin
        sizes[a] <= '0;
      end
    end else if (sizeWe) begin
      sizes[sizeArray] <= sizeData;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state      <= arrayCtlPkg::Idle;
      step       <= '0;
      rsp.finish <= 1'b0;
      markArray  <= '0;
      markIndex  <= '0;
    end else begin
      rsp.finish <= 1'b0;
      if (take) begin
        step <= '0;
        case (cmd.opcode)
          arrayOpPkg::Clear:    state <= arrayCtlPkg::Clearing;
          arrayOpPkg::Index,
          arrayOpPkg::Less,
          arrayOpPkg::Greater:  state <= arrayCtlPkg::Scanning;
          arrayOpPkg::Insert:   state <= arrayCtlPkg::Shifting;
          arrayOpPkg::MoveCopy: state <= arrayCtlPkg::Copying;
          arrayOpPkg::MoveMark: begin
            markArray  <= cmd.array;
            markIndex  <= cmd.index;
            rsp.finish <= 1'b1;
          end
          default: rsp.finish <= 1'b1;          // Done in one step
        endcase
      end else if (state != arrayCtlPkg::Idle) begin
        step <= step + 1'b1;
        if (lastStep) begin
          state      <= arrayCtlPkg::Idle;
          rsp.finish <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      curOp        <= cmd.opcode;
      curArray     <= cmd.array;
      curIndex     <= cmd.index;
      curData      <= cmd.data;
      acc          <= '0;
      rsp.opcode   <= cmd.opcode;
      rsp.value    <= cmd.data;             // Write echoes its data
      rsp.hasValue <= 1'b0;
      case (cmd.opcode)
        arrayOpPkg::Write: rsp.hasValue <= 1'b1;
        arrayOpPkg::Read: begin
          rsp.hasValue <= 1'b1;
          rsp.value    <= mem[cmd.array][cmd.index];
        end
        arrayOpPkg::Size: begin
          rsp.hasValue <= 1'b1;
          rsp.value    <= `DATA_BITS'(cmdSize);
        end
        arrayOpPkg::Index,
        arrayOpPkg::Less,
        arrayOpPkg::Greater: rsp.hasValue <= 1'b1;
        arrayOpPkg::Pop: begin
          rsp.hasValue <= !cmdEmpty;          // Empty pop keeps out
          rsp.value    <= mem[cmd.array][popSlot];
        end
        default: ;
      endcase
    end else if (state == arrayCtlPkg::Scanning) begin
      acc       <= accNext;
      rsp.value <= `DATA_BITS'(accNext);
    end
  end

endmodule

//--- hdl/commandDecoder.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

module commandDecoder (
  input  logic                   clock,
  input  logic                   arstN,
  input  logic                   start,
  input  logic [7:0]             action,
  input  arrayCtlPkg::arrayId_t  array,
  input  logic [`INDEX_BITS-1:0] index,
  input  logic [`DATA_BITS-1:0]  in,
  input  logic                   busy,
  arrayCmdIf.source              cmd
);

  arrayOpPkg::opcode_t op;
  logic                known;
  logic                accept;

  assign op = arrayOpPkg::opcode_t'(action);

  always_comb begin
    case (op)
      arrayOpPkg::Clear,
      arrayOpPkg::Write,
      arrayOpPkg::Read,
      arrayOpPkg::Size,
      arrayOpPkg::Inc,
      arrayOpPkg::Dec,
      arrayOpPkg::Index,
      arrayOpPkg::Less,
      arrayOpPkg::Greater,
      arrayOpPkg::Insert,
      arrayOpPkg::MoveMark,
      arrayOpPkg::MoveCopy,
      arrayOpPkg::Push,
      arrayOpPkg::Pop: known = 1'b1;
      default:         known = 1'b0;        // Codes 11, 16 and the rest
    endcase
  end

  // Also hold off while the previous pulse is still in flight
  assign accept = start && !busy && !cmd.valid && known;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= accept;                  // Single cycle pulse
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cmd.opcode <= op;
      cmd.array  <= array;
      cmd.index  <= index;
      cmd.data   <= in;
    end
  end

endmodule

//--- hdl/arrayIf.sv
`timescale 1ns/1ps
`include "arrayMem_settings.svh"

interface arrayCmdIf;
  logic                   valid;        // One-cycle pulse per accepted command
  arrayOpPkg::opcode_t    opcode;
  arrayCtlPkg::arrayId_t  array;
  logic [`INDEX_BITS-1:0] index;
  logic [`DATA_BITS-1:0]  data;

  modport source (output valid, opcode, array, index, data);
  modport sink (input valid, opcode, array, index, data);
endinterface

interface arrayRspIf;
  logic                  finish;        // End of each command
  arrayOpPkg::opcode_t   opcode;        // Command that finished
  logic [`DATA_BITS-1:0] value;
  logic                  hasValue;      // Out must take value

  modport source (output finish, opcode, value, hasValue);
  modport sink (input finish, opcode, value, hasValue);
endinterface

//--- hdl/arrayCtlPkg.sv
`include "arrayMem_settings.svh"

package arrayCtlPkg;

  // Sequencer states for the multi-cycle commands
  typedef enum logic [2:0] {
    Idle,                               // Waiting for a command
    Clearing,                           // One size per clock
    Scanning,                           // Index, Less and Greater
    Shifting,                           // Insert, top slot down
    Copying                             // Long move, one element per clock
  } state_t;

  typedef logic [`INDEX_BITS:0] size_t;              // 0 to SLOTS inclusive
  typedef logic [`ARRAY_BITS-1:0] arrayId_t;         // Array select

  // Step counter wide enough for both the array walk and the slot walk
  typedef logic [((`ARRAY_BITS > `INDEX_BITS) ? `ARRAY_BITS : `INDEX_BITS)-1:0] step_t;

endpackage

//--- hdl/arrayOpPkg.sv
package arrayOpPkg;

  // Host command codes, 11 and 16 stay unused
  typedef enum logic [7:0] {
    Clear    = 8'd1,                    // Zero all sizes
    Write    = 8'd2,                    // Write one element
    Read     = 8'd3,                    // Read one element
    Size     = 8'd4,                    // Report array size
    Inc      = 8'd5,                    // Grow size if room
    Dec      = 8'd6,                    // Shrink size if not empty
    Index    = 8'd7,                    // Last match position plus one
    Less     = 8'd8,                    // Count elements below value
    Greater  = 8'd9,                    // Count elements above value
    Insert   = 8'd10,                   // Shift up and store
    MoveMark = 8'd12,                   // Remember long move source
    MoveCopy = 8'd13,                   // Copy run from marked source
    Push     = 8'd14,                   // Append if room
    Pop      = 8'd15                    // Remove last if any
  } opcode_t;

endpackage

//--- hdl/arrayMem_settings.svh
`ifndef ARRAYMEM_SETTINGS_SVH
`define ARRAYMEM_SETTINGS_SVH

// Number of arrays held by the engine
`define ARRAYS 16
// Element index width
`define INDEX_BITS 3
// Element width
`define DATA_BITS 8
// Elements per array
`define SLOTS (2 ** `INDEX_BITS)
// Array select width
`define ARRAY_BITS $clog2(`ARRAYS)

`endif
